//--- Bender.yml
package:
  name: periph_wb8

sources:
  - include_dirs:
      - logic
    files:
      - logic/wb8_bus_pkg.sv
      - logic/periph_pkg.sv
      - logic/wb8_if.sv
      - logic/wb8_decoder.sv
      - logic/leds_wb8.sv
      - logic/timer_wb8.sv
      - logic/prng_wb8.sv
      - logic/bram_wb8.sv
      - logic/periph_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - dv/periph_tb.sv

//--- dv/periph_tb.sv
`timescale 1ns/10ps

`include "wb8_defs.svh"

module periph_tb;
    import wb8_bus_pkg::*;
    import periph_pkg::*;

    localparam int TABLE_LEN_MAX = 80;
    localparam int IRQ_MIN = 5 * `WB8_TIMER_PRESCALE - 4;
    localparam int IRQ_MAX = 5 * `WB8_TIMER_PRESCALE + 4;
    localparam int CYCLE_LIMIT = 16 + TABLE_LEN_MAX * 8 + 3 * IRQ_MAX;
    localparam logic [31:0] LEDS_ADR  = 32'hFFFFFFF0;
    localparam logic [31:0] TIMER_ADR = 32'hFFFFFD00;
    localparam logic [31:0] PRNG_ADR  = 32'hFFFFFE00;
    localparam logic [7:0] CTRL_EN  = 8'(1 << TMR_CTRL_EN);
    localparam logic [7:0] CTRL_IE  = 8'(1 << TMR_CTRL_IE);
    localparam logic [7:0] CTRL_CLR = 8'(1 << TMR_CTRL_CLR);

    typedef struct {
        wb8_access_e acc;
        logic [31:0] adr;
        logic [7:0]  wdat;
        logic [7:0]  exp;
        bit          cmp;
    } entry_t;

    logic                  clk;
    logic                  rst_n;
    logic                  bus_stb;
    logic                  bus_we;
    logic [`WB8_ADR_W-1:0] bus_adr;
    logic [`WB8_DAT_W-1:0] bus_dat_w;
    logic [`WB8_DAT_W-1:0] bus_dat_r;
    logic                  bus_ack;
    logic [`WB8_DAT_W-1:0] leds;
    logic                  irq;

    entry_t      stim_q[$];
    logic [7:0]  ram_shadow [2 ** `WB8_RAM_ADR_W];
    logic [7:0]  led_model;
    logic [31:0] prng_model;
    logic [31:0] rng_state;
    int          errors;
    int          tests;
    int          accesses;
    int          acks;
    int          cycles;

    periph_top u_dut (
        .clk       (clk),
        .rst_n_i   (rst_n),
        .bus_stb_i (bus_stb),
        .bus_we_i  (bus_we),
        .bus_adr_i (bus_adr),
        .bus_dat_i (bus_dat_w),
        .bus_dat_o (bus_dat_r),
        .bus_ack_o (bus_ack),
        .leds_o    (leds),
        .irq_o     (irq)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // one count per acknowledge pulse
    always @(negedge clk) begin
        if (bus_ack) begin
            acks++;
        end
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Test FAILED");
        $finish;
    end

    // xorshift32 with shifts 13 left, 17 right and 5 left
    function automatic logic [31:0] prng_step(input logic [31:0] s);
        logic [31:0] t;
        t = s ^ (s << 13);
        t = t ^ (t >> 17);
        return t ^ (t << 5);
    endfunction

    function logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string msg);
        if (got !== exp) begin
            $display("error @ %0t ns: %s, got 0x%0h expected 0x%0h", $time, msg, got, exp);
            errors++;
        end
    endtask

    task automatic add_entry(input wb8_access_e acc, input logic [31:0] adr,
                             input logic [7:0] wdat, input logic [7:0] exp, input bit cmp);
        entry_t e;
        e = '{acc, adr, wdat, exp, cmp};
        stim_q.push_back(e);
    endtask

    // entered and left on a falling edge
    task automatic bus_access(input wb8_access_e acc, input logic [31:0] adr,
                              input logic [7:0] wdat, output logic [7:0] rdat);
        int waited;
        waited    = 1;
        bus_stb   = 1'b1;
        bus_we    = (acc == ACC_WRITE);
        bus_adr   = adr;
        bus_dat_w = wdat;
        accesses++;
        @(negedge clk);
        bus_stb = 1'b0;
        while (!bus_ack && waited < 8) begin
            @(negedge clk);
            waited++;
        end
        rdat = bus_dat_r;
        if (!bus_ack) begin
            $display("no acknowledge within 8 cycles for the access to 0x%08h", adr);
            errors++;
        end else begin
            check_value(waited, 1, $sformatf("acknowledge delay at 0x%08h", adr));
        end
        @(negedge clk);
        check_value(bus_ack, 0, $sformatf("acknowledge held past one cycle at 0x%08h", adr));
    endtask

    task automatic run_table();
        logic [7:0] rdat;
        foreach (stim_q[i]) begin
            bus_access(stim_q[i].acc, stim_q[i].adr, stim_q[i].wdat, rdat);
            if (stim_q[i].cmp) begin
                check_value(rdat, stim_q[i].exp, $sformatf("read of 0x%08h", stim_q[i].adr));
            end
        end
        stim_q.delete();
    endtask

    task automatic finish_test(input string name, input int err_start);
        tests++;
        $display("test %0d %s done, %0d errors", tests, name, errors - err_start);
    endtask

    initial begin
        int                       err_start;
        int                       waited;
        logic [31:0]              r;
        logic [31:0]              mirror;
        logic [`WB8_RAM_ADR_W-1:0] ram_adrs [20];
        rst_n     = 1'b0;
        bus_stb   = 1'b0;
        bus_we    = 1'b0;
        bus_adr   = '0;
        bus_dat_w = '0;
        rng_state = 32'h4930;
        errors    = 0;
        tests     = 0;
        accesses  = 0;
        acks      = 0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        err_start = errors;
        check_value(leds, 0, "leds_o after reset");
        check_value(irq, 0, "irq_o after reset");
        add_entry(ACC_READ, LEDS_ADR, 8'h00, 8'h00, 1'b1);
        run_table();
        finish_test("reset values", err_start);

        err_start = errors;
        led_model = 8'h5A;
        add_entry(ACC_WRITE, LEDS_ADR, led_model, 8'h00, 1'b0);
        add_entry(ACC_READ, LEDS_ADR, 8'h00, led_model, 1'b1);
        run_table();
        check_value(leds, led_model, "leds_o after write");
        finish_test("led register", err_start);

        err_start = errors;
        for (int i = 0; i < 20; i++) begin
            r = next_rand();
            ram_adrs[i] = r[16 +: `WB8_RAM_ADR_W];
            ram_shadow[ram_adrs[i]] = r[31:24];
            add_entry(ACC_WRITE, 32'(ram_adrs[i]), r[31:24], 8'h00, 1'b0);
        end
        for (int i = 0; i < 20; i++) begin
            add_entry(ACC_READ, 32'(ram_adrs[i]), 8'h00, ram_shadow[ram_adrs[i]], 1'b1);
        end
        // upper bits set but outside every base
        mirror = 32'h0001_2345;
        r = next_rand();
        ram_shadow[mirror[`WB8_RAM_ADR_W-1:0]] = r[31:24];
        add_entry(ACC_WRITE, mirror, r[31:24], 8'h00, 1'b0);
        add_entry(ACC_READ, 32'(mirror[`WB8_RAM_ADR_W-1:0]), 8'h00, r[31:24], 1'b1);
        run_table();
        finish_test("ram random and mirror", err_start);

        err_start = errors;
        prng_model = next_rand();
        for (int b = 0; b < 4; b++) begin
            add_entry(ACC_WRITE, PRNG_ADR + b, prng_model[b*8 +: 8], 8'h00, 1'b0);
        end
        for (int w = 0; w < 3; w++) begin
            for (int b = 0; b < 4; b++) begin
                add_entry(ACC_READ, PRNG_ADR + b, 8'h00, prng_model[b*8 +: 8], 1'b1);
            end
            prng_model = prng_step(prng_model);
        end
        run_table();
        finish_test("prng seed and words", err_start);

        err_start = errors;
        add_entry(ACC_WRITE, TIMER_ADR + TMR_PERIOD_LO, 8'd5, 8'h00, 1'b0);
        add_entry(ACC_WRITE, TIMER_ADR + TMR_PERIOD_HI, 8'd0, 8'h00, 1'b0);
        add_entry(ACC_WRITE, TIMER_ADR + TMR_CTRL, CTRL_EN | CTRL_IE, 8'h00, 1'b0);
        run_table();
        waited = 0;
        while (!irq && waited < IRQ_MAX) begin
            @(negedge clk);
            waited++;
        end
        if (!irq) begin
            $display("irq_o did not rise within %0d cycles of the timer start", IRQ_MAX);
            errors++;
        end else if (waited < IRQ_MIN) begin
            $display("irq_o rose after %0d cycles, sooner than the %0d allowed", waited, IRQ_MIN);
            errors++;
        end
        add_entry(ACC_READ, TIMER_ADR + TMR_STATUS, 8'h00, 8'h01, 1'b1);
        add_entry(ACC_WRITE, TIMER_ADR + TMR_CTRL, CTRL_EN | CTRL_IE | CTRL_CLR, 8'h00, 1'b0);
        run_table();
        check_value(irq, 0, "irq_o after flag clear");
        add_entry(ACC_READ, TIMER_ADR + TMR_STATUS, 8'h00, 8'h00, 1'b1);
        run_table();
        finish_test("timer interrupt", err_start);

        err_start = errors;
        add_entry(ACC_WRITE, TIMER_ADR + TMR_CTRL, CTRL_EN | CTRL_CLR, 8'h00, 1'b0);
        run_table();
        waited = 0;
        repeat (2 * IRQ_MAX) begin
            @(negedge clk);
            if (irq) begin
                waited++;
            end
        end
        check_value(waited, 0, "cycles of irq_o high with the enable off");
        add_entry(ACC_READ, TIMER_ADR + TMR_STATUS, 8'h00, 8'h01, 1'b1);
        add_entry(ACC_WRITE, TIMER_ADR + TMR_CTRL, CTRL_CLR, 8'h00, 1'b0);
        add_entry(ACC_READ, TIMER_ADR + TMR_STATUS, 8'h00, 8'h00, 1'b1);
        run_table();
        check_value(acks, accesses, "acknowledges over the whole run");
        finish_test("timer masked and ack count", err_start);

        $display("%0d tests, %0d accesses, %0d errors", tests, accesses, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+logic
logic/wb8_bus_pkg.sv
logic/periph_pkg.sv
logic/wb8_if.sv
logic/wb8_decoder.sv
logic/leds_wb8.sv
logic/timer_wb8.sv
logic/prng_wb8.sv
logic/bram_wb8.sv
logic/periph_top.sv
dv/periph_tb.sv

//--- logic/bram_wb8.sv
`timescale 1ns/10ps

`include "wb8_defs.svh"

module bram_wb8 (
    input  logic clk,
    input  logic rst_n_i,
    wb8_if.slave bus
);

    localparam int DEPTH = 2 ** `WB8_RAM_ADR_W;

    logic [`WB8_DAT_W-1:0]    mem [DEPTH];
    logic [`WB8_DAT_W-1:0]    dat_r_q;
    logic                     ack_q;
    logic [`WB8_RAM_ADR_W-1:0] word_adr;

    // upper bits dropped, so the RAM repeats through its region
    assign word_adr = bus.adr[`WB8_RAM_ADR_W-1:0];

    always_ff @(posedge clk) begin
        if (bus.stb) begin
            if (bus.we) begin
                mem[word_adr] <= bus.dat_w;
            end
            dat_r_q <= mem[word_adr];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= bus.stb;
        end
    end

    assign bus.dat_r = dat_r_q;
    assign bus.ack   = ack_q;

endmodule

//--- logic/leds_wb8.sv
`timescale 1ns/10ps

`include "wb8_defs.svh"

module leds_wb8 (
    input  logic                  clk,
    input  logic                  rst_n_i,
    wb8_if.slave                  bus,
    output logic [`WB8_DAT_W-1:0] leds_o
);

    logic [`WB8_DAT_W-1:0] leds_q;
    logic                  ack_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            leds_q <= '0;
            ack_q  <= 1'b0;
        end else begin
            ack_q <= bus.stb;
            if (bus.stb && bus.we) begin
                leds_q <= bus.dat_w;
            end
        end
    end

    // every offset in the window reads the register
    assign bus.dat_r = leds_q;
    assign bus.ack   = ack_q;
    assign leds_o    = leds_q;

endmodule

//--- logic/periph_pkg.sv
package periph_pkg;

    // timer register offsets on adr[2:0]
    typedef enum logic [2:0] {
        TMR_CTRL      = 3'd0,
        TMR_STATUS    = 3'd1,
        TMR_PERIOD_LO = 3'd2,
        TMR_PERIOD_HI = 3'd3
    } timer_reg_e;

    // control register bits
    localparam int TMR_CTRL_EN  = 0;
    localparam int TMR_CTRL_IE  = 1;
    // write-one-to-clear of the flag, reads back as zero
    localparam int TMR_CTRL_CLR = 2;

endpackage

//--- logic/periph_top.sv
`timescale 1ns/10ps

`include "wb8_defs.svh"

module periph_top (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  bus_stb_i,
    input  logic                  bus_we_i,
    input  logic [`WB8_ADR_W-1:0] bus_adr_i,
    input  logic [`WB8_DAT_W-1:0] bus_dat_i,
    output logic [`WB8_DAT_W-1:0] bus_dat_o,
    output logic                  bus_ack_o,
    output logic [`WB8_DAT_W-1:0] leds_o,
    output logic                  irq_o
);

    wb8_if if_ram ();
    wb8_if if_timer ();
    wb8_if if_prng ();
    wb8_if if_leds ();

    wb8_decoder u_decoder (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .bus_stb_i (bus_stb_i),
        .bus_we_i  (bus_we_i),
        .bus_adr_i (bus_adr_i),
        .bus_dat_i (bus_dat_i),
        .bus_dat_o (bus_dat_o),
        .bus_ack_o (bus_ack_o),
        .if_ram    (if_ram.master),
        .if_timer  (if_timer.master),
        .if_prng   (if_prng.master),
        .if_leds   (if_leds.master)
    );

    leds_wb8 u_leds (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .bus     (if_leds.slave),
        .leds_o  (leds_o)
    );

    timer_wb8 u_timer (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .bus     (if_timer.slave),
        .irq_o   (irq_o)
    );

    prng_wb8 u_prng (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .bus     (if_prng.slave)
    );

    // default region, catches everything unclaimed
    bram_wb8 u_bram (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .bus     (if_ram.slave)
    );

endmodule

//--- logic/prng_wb8.sv
`timescale 1ns/10ps

`include "wb8_defs.svh"

module prng_wb8 (
    input  logic clk,
    input  logic rst_n_i,
    wb8_if.slave bus
);

    logic [31:0]           state_q;
    logic [`WB8_DAT_W-1:0] dat_r_q;
    logic                  ack_q;
    logic [1:0]            sel;

    // xorshift32, shifts 13 / 17 / 5
    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    assign sel = bus.adr[1:0];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= 32'h1;
            ack_q   <= 1'b0;
        end else begin
            ack_q <= bus.stb;
            if (bus.stb && bus.we) begin
                state_q[sel*8 +: 8] <= bus.dat_w;
            end else if (bus.stb && sel == 2'd3) begin
                // byte 3 closes a word, step after it is returned
                state_q <= xorshift(state_q);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus.stb) begin
            dat_r_q <= state_q[sel*8 +: 8];
        end
    end

    assign bus.dat_r = dat_r_q;
    assign bus.ack   = ack_q;

endmodule

//--- logic/timer_wb8.sv
`timescale 1ns/10ps

`include "wb8_defs.svh"

module timer_wb8 (
    input  logic clk,
    input  logic rst_n_i,
    wb8_if.slave bus,
    output logic irq_o
);
    import periph_pkg::*;

    localparam int PRE_W = $clog2(`WB8_TIMER_PRESCALE);
    localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(`WB8_TIMER_PRESCALE - 1);

    logic [PRE_W-1:0]      pre_q;
    logic [15:0]           cnt_q;
    logic [15:0]           period_q;
    logic                  en_q;
    logic                  ie_q;
    logic                  flag_q;
    logic                  ack_q;
    logic [`WB8_DAT_W-1:0] rd_data;
    logic [`WB8_DAT_W-1:0] dat_r_q;
    logic                  wr;
    logic                  tick;
    logic                  hit;
    logic                  clr;

    assign wr   = bus.stb & bus.we;
    assign tick = en_q & (pre_q == PRE_LAST);
    // period of zero never fires
    assign hit  = tick & (period_q != 16'd0) & (cnt_q + 16'd1 == period_q);
    assign clr  = wr & (bus.adr[2:0] == TMR_CTRL) & bus.dat_w[TMR_CTRL_CLR];

    // prescaler restarts whenever the timer is stopped
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pre_q <= '0;
            cnt_q <= '0;
        end else if (!en_q) begin
            pre_q <= '0;
        end else if (tick) begin
            pre_q <= '0;
            cnt_q <= hit ? 16'd0 : cnt_q + 16'd1;
        end else begin
            pre_q <= pre_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            en_q     <= 1'b0;
            ie_q     <= 1'b0;
            period_q <= '0;
            flag_q   <= 1'b0;
            ack_q    <= 1'b0;
        end else begin
            ack_q <= bus.stb;
            if (wr) begin
                case (bus.adr[2:0])
                    TMR_CTRL: begin
                        en_q <= bus.dat_w[TMR_CTRL_EN];
                        ie_q <= bus.dat_w[TMR_CTRL_IE];
                    end
                    TMR_PERIOD_LO: period_q[7:0] <= bus.dat_w;
                    TMR_PERIOD_HI: period_q[15:8] <= bus.dat_w;
                    default: ;
                endcase
            end
            // a new event wins over a clear in the same cycle
            if (hit) begin
                flag_q <= 1'b1;
            end else if (clr) begin
                flag_q <= 1'b0;
            end
        end
    end

    always_comb begin
        rd_data = '0;
        case (bus.adr[2:0])
            TMR_CTRL: begin
                rd_data[TMR_CTRL_EN] = en_q;
                rd_data[TMR_CTRL_IE] = ie_q;
            end
            TMR_STATUS: rd_data[0] = flag_q;
            TMR_PERIOD_LO: rd_data = period_q[7:0];
            TMR_PERIOD_HI: rd_data = period_q[15:8];
            default: rd_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (bus.stb) begin
            dat_r_q <= rd_data;
        end
    end

    assign bus.dat_r = dat_r_q;
    assign bus.ack   = ack_q;
    assign irq_o     = flag_q & ie_q;

endmodule

//--- logic/wb8_bus_pkg.sv
package wb8_bus_pkg;

    // region picked by the address decoder
    typedef enum logic [1:0] {
        REGION_RAM,
        REGION_TIMER,
        REGION_PRNG,
        REGION_LEDS
    } wb8_region_e;

    // direction of one bus access
    typedef enum logic {
        ACC_READ,
        ACC_WRITE
    } wb8_access_e;

endpackage

//--- logic/wb8_decoder.sv
`timescale 1ns/10ps

`include "wb8_defs.svh"

module wb8_decoder (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  bus_stb_i,
    input  logic                  bus_we_i,
    input  logic [`WB8_ADR_W-1:0] bus_adr_i,
    input  logic [`WB8_DAT_W-1:0] bus_dat_i,
    output logic [`WB8_DAT_W-1:0] bus_dat_o,
    output logic                  bus_ack_o,
    wb8_if.master                 if_ram,
    wb8_if.master                 if_timer,
    wb8_if.master                 if_prng,
    wb8_if.master                 if_leds
);
    import wb8_bus_pkg::*;

    wb8_region_e region;
    wb8_region_e region_q;
    wb8_access_e acc;
    logic        wr;

    // same priority as the full SoC map, RAM takes the rest
    always_comb begin
        if (bus_adr_i[`WB8_ADR_W-1:`WB8_PAGE_LSB] == `WB8_BASE_TIMER) begin
            region = REGION_TIMER;
        end else if (bus_adr_i[`WB8_ADR_W-1:`WB8_PAGE_LSB] == `WB8_BASE_PRNG) begin
            region = REGION_PRNG;
        end else if (bus_adr_i[`WB8_ADR_W-1:`WB8_LEDS_LSB] == `WB8_BASE_LEDS) begin
            region = REGION_LEDS;
        end else begin
            region = REGION_RAM;
        end
    end

    assign acc = bus_we_i ? ACC_WRITE : ACC_READ;
    assign wr  = (acc == ACC_WRITE);

    // shared request lines
    assign if_ram.adr     = bus_adr_i;
    assign if_ram.we      = wr;
    assign if_ram.dat_w   = bus_dat_i;
    assign if_timer.adr   = bus_adr_i;
    assign if_timer.we    = wr;
    assign if_timer.dat_w = bus_dat_i;
    assign if_prng.adr    = bus_adr_i;
    assign if_prng.we     = wr;
    assign if_prng.dat_w  = bus_dat_i;
    assign if_leds.adr    = bus_adr_i;
    assign if_leds.we     = wr;
    assign if_leds.dat_w  = bus_dat_i;

    // only the addressed slave sees the strobe
    assign if_ram.stb   = bus_stb_i & (region == REGION_RAM);
    assign if_timer.stb = bus_stb_i & (region == REGION_TIMER);
    assign if_prng.stb  = bus_stb_i & (region == REGION_PRNG);
    assign if_leds.stb  = bus_stb_i & (region == REGION_LEDS);

    // remember who was addressed for the response cycle
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            region_q <= REGION_RAM;
        end else if (bus_stb_i) begin
            region_q <= region;
        end
    end

    always_comb begin
        case (region_q)
            REGION_TIMER: begin
                bus_dat_o = if_timer.dat_r;
                bus_ack_o = if_timer.ack;
            end
            REGION_PRNG: begin
                bus_dat_o = if_prng.dat_r;
                bus_ack_o = if_prng.ack;
            end
            REGION_LEDS: begin
                bus_dat_o = if_leds.dat_r;
                bus_ack_o = if_leds.ack;
            end
            default: begin
                bus_dat_o = if_ram.dat_r;
                bus_ack_o = if_ram.ack;
            end
        endcase
    end

endmodule

//--- logic/wb8_defs.svh
`ifndef WB8_DEFS_SVH
`define WB8_DEFS_SVH

// bus widths
`define WB8_ADR_W 32
`define WB8_DAT_W 8

// 2 KiB block RAM, mirrored through the default region
`define WB8_RAM_ADR_W 11

// clock cycles per timer tick
`define WB8_TIMER_PRESCALE 4

// lowest address bit compared for the 256-byte pages
`define WB8_PAGE_LSB 8

// lowest address bit compared for the LED window
`define WB8_LEDS_LSB 4

// upper address bits of each region
`define WB8_BASE_TIMER 24'hFFFFFD
`define WB8_BASE_PRNG 24'hFFFFFE
`define WB8_BASE_LEDS 28'hFFFFFFF

`endif

//--- logic/wb8_if.sv
`timescale 1ns/10ps

`include "wb8_defs.svh"

interface wb8_if;

    logic                  stb;
    logic                  we;
    logic [`WB8_ADR_W-1:0] adr;
    logic [`WB8_DAT_W-1:0] dat_w;
    logic [`WB8_DAT_W-1:0] dat_r;
    logic                  ack;

    modport master (
        output stb, we, adr, dat_w,
        input  dat_r, ack
    );

    modport slave (
        input  stb, we, adr, dat_w,
        output dat_r, ack
    );

endinterface
